// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tiny_core_tb
FILELIST  := tiny_core.f

SOURCES := $(shell cat $(FILELIST))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

// File: sim/tiny_core_tb.sv
// --------------------
// random program over x0..x7 against an in-order model
// DUT built with num_cores 4 and core_id 2
// --------------------
`default_nettype none

module tiny_core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int n_prog     = 300;
  localparam int n_words    = 300;
  localparam int n_init     = 7;
  localparam int n_tail     = 9;
  localparam int max_cycles = 20000;

  // instruction kinds with r-type 0..9 in alu order and op-imm 10..18
  localparam int k_op_last  = 9;
  localparam int k_imm_last = 18;
  localparam int k_lui      = 19;
  localparam int k_mngr     = 20;
  localparam int k_numcores = 21;
  localparam int k_coreid   = 22;
  localparam int k_csrw     = 23;

  logic        clk;
  logic        reset;
  logic        inst_valid;
  logic [31:0] inst;
  logic        inst_ready;
  logic        mngr2proc_valid;
  logic [31:0] mngr2proc_data;
  logic        mngr2proc_ready;
  logic        proc2mngr_valid;
  logic [31:0] proc2mngr_data;
  logic        proc2mngr_ready;

  tiny_core #(
    .num_cores (4),
    .core_id   (2)
  ) DUT (
    .clk               (clk),
    .reset             (reset),
    .inst_valid_i      (inst_valid),
    .inst_i            (inst),
    .inst_ready_o      (inst_ready),
    .mngr2proc_valid_i (mngr2proc_valid),
    .mngr2proc_data_i  (mngr2proc_data),
    .mngr2proc_ready_o (mngr2proc_ready),
    .proc2mngr_valid_o (proc2mngr_valid),
    .proc2mngr_data_o  (proc2mngr_data),
    .proc2mngr_ready_i (proc2mngr_ready)
  );

  always #4 clk = ~clk;

  // --------------------
  // program, manager words and model state
  // --------------------

  int          p_kind  [n_prog];
  logic [2:0]  p_rd    [n_prog];
  logic [2:0]  p_rs1   [n_prog];
  logic [2:0]  p_rs2   [n_prog];
  logic [19:0] p_imm   [n_prog];
  logic [31:0] prog    [n_prog];
  logic [31:0] m_words [n_words];
  logic [31:0] mregs   [8];
  logic [31:0] exp_q   [$];

  logic [31:0] lfsr;
  int          inst_idx;
  int          mngr_idx;
  int          model_mngr;
  int          out_count;
  int          check_count;
  int          err_count;
  int          cycles;
  logic        inst_fire;
  logic        mngr_fire;
  logic        hold_pending;
  logic [31:0] hold_data;

  // fibonacci lfsr over x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one step per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] encode(int k, logic [2:0] rd, logic [2:0] rs1,
                                         logic [2:0] rs2, logic [19:0] imm);
    logic [4:0] d;
    logic [4:0] a;
    logic [4:0] b;
    d = {2'b0, rd};
    a = {2'b0, rs1};
    b = {2'b0, rs2};
    case (k)
      0:  return {7'h00, b, a, 3'd0, d, 7'h33};
      1:  return {7'h20, b, a, 3'd0, d, 7'h33};
      2:  return {7'h00, b, a, 3'd7, d, 7'h33};
      3:  return {7'h00, b, a, 3'd6, d, 7'h33};
      4:  return {7'h00, b, a, 3'd4, d, 7'h33};
      5:  return {7'h00, b, a, 3'd2, d, 7'h33};
      6:  return {7'h00, b, a, 3'd3, d, 7'h33};
      7:  return {7'h00, b, a, 3'd1, d, 7'h33};
      8:  return {7'h00, b, a, 3'd5, d, 7'h33};
      9:  return {7'h20, b, a, 3'd5, d, 7'h33};
      10: return {imm[11:0], a, 3'd0, d, 7'h13};
      11: return {imm[11:0], a, 3'd7, d, 7'h13};
      12: return {imm[11:0], a, 3'd6, d, 7'h13};
      13: return {imm[11:0], a, 3'd4, d, 7'h13};
      14: return {imm[11:0], a, 3'd2, d, 7'h13};
      15: return {imm[11:0], a, 3'd3, d, 7'h13};
      // immediate shifts carry shamt in bits 24:20
      16: return {7'h00, imm[4:0], a, 3'd1, d, 7'h13};
      17: return {7'h00, imm[4:0], a, 3'd5, d, 7'h13};
      18: return {7'h20, imm[4:0], a, 3'd5, d, 7'h13};
      19: return {imm, d, 7'h37};
      20: return {12'hFC0, 5'd0, 3'd2, d, 7'h73};
      21: return {12'hFC1, 5'd0, 3'd2, d, 7'h73};
      22: return {12'hF14, 5'd0, 3'd2, d, 7'h73};
      default: return {12'h7C0, a, 3'd1, 5'd0, 7'h73};
    endcase
  endfunction

  // rv32i semantics with op numbered like the r-type kinds
  function automatic logic [31:0] alu_ref(int op, logic [31:0] a, logic [31:0] b);
    case (op)
      0: return a + b;
      1: return a - b;
      2: return a & b;
      3: return a | b;
      4: return a ^ b;
      5: return {31'b0, $signed(a) < $signed(b)};
      6: return {31'b0, a < b};
      7: return a << b[4:0];
      8: return a >> b[4:0];
      default: return $signed(a) >>> b[4:0];
    endcase
  endfunction

  task automatic build_program();
    int k;
    for (int i = 0; i < n_words; i++) begin
      m_words[i] = rand_bits(32);
    end
    for (int i = 0; i < n_prog; i++) begin
      p_rd[i]  = 3'(rand_bits(3));
      p_rs1[i] = 3'(rand_bits(3));
      p_rs2[i] = 3'(rand_bits(3));
      p_imm[i] = 20'(rand_bits(20));
      k = int'(rand_bits(5));
      if (k > k_csrw) begin
        k = k_csrw;
      end
      if (i < n_init) begin
        // x1..x7 loaded from the manager so rf and model agree
        k = k_mngr;
        p_rd[i] = 3'(i + 1);
      end else if (i == n_prog - n_tail) begin
        // addi into x0 that the tail reads back
        k = 10;
        p_rd[i] = 3'd0;
      end else if (i > n_prog - n_tail) begin
        // tail dumps x0..x7 to the manager
        k = k_csrw;
        p_rs1[i] = 3'(i - (n_prog - n_tail + 1));
      end
      p_kind[i] = k;
      prog[i] = encode(k, p_rd[i], p_rs1[i], p_rs2[i], p_imm[i]);
    end
  endtask

  // --------------------
  // architectural model run on each instruction transfer
  // --------------------

  task automatic model_exec(input int idx);
    int          k;
    logic [31:0] a;
    logic [31:0] res;
    logic        wr;
    k   = p_kind[idx];
    a   = mregs[p_rs1[idx]];
    res = '0;
    wr  = 1'b1;
    if (k <= k_op_last) begin
      res = alu_ref(k, a, mregs[p_rs2[idx]]);
    end else if (k <= k_imm_last) begin
      // sign-extended i-immediate whose low 5 bits serve as shamt
      res = alu_ref((k == 10) ? 0 : k - 9, a, {{20{p_imm[idx][11]}}, p_imm[idx][11:0]});
    end else if (k == k_lui) begin
      res = {p_imm[idx], 12'b0};
    end else if (k == k_mngr) begin
      res = m_words[model_mngr];
      model_mngr++;
    end else if (k == k_numcores) begin
      res = 32'd4;
    end else if (k == k_coreid) begin
      res = 32'd2;
    end else begin
      exp_q.push_back(a);
      wr = 1'b0;
    end
    // x0 stays zero
    if (wr && (p_rd[idx] != 3'd0)) begin
      mregs[p_rd[idx]] = res;
    end
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] want,
                                 input logic [31:0] got);
    $display("** Error [%s] expected %h actual %h", name, want, got);
    err_count++;
  endtask

  // --------------------
  // per-edge monitor and driver
  // --------------------

  // runs at the rising edge and sees pre-edge values
  task automatic observe_edge();
    logic [31:0] want;
    inst_fire = inst_valid && inst_ready;
    mngr_fire = mngr2proc_valid && mngr2proc_ready;
    // held word must survive back-pressure
    if (hold_pending) begin
      check_count++;
      if (proc2mngr_valid !== 1'b1) begin
        report_mismatch("backpressure_valid", 32'd1, {31'b0, proc2mngr_valid});
      end
      if (proc2mngr_data !== hold_data) begin
        report_mismatch("backpressure_data", hold_data, proc2mngr_data);
      end
    end
    hold_pending = proc2mngr_valid && !proc2mngr_ready;
    hold_data    = proc2mngr_data;
    if (inst_fire) begin
      model_exec(inst_idx);
      inst_idx++;
    end
    if (mngr_fire) begin
      mngr_idx++;
    end
    if (proc2mngr_valid && proc2mngr_ready) begin
      if (exp_q.size() == 0) begin
        $display("proc2mngr sent %h while no result was outstanding", proc2mngr_data);
        err_count++;
      end else begin
        want = exp_q.pop_front();
        check_count++;
        out_count++;
        if (proc2mngr_data !== want) begin
          report_mismatch("proc2mngr_data", want, proc2mngr_data);
        end
      end
    end
  endtask

  // valid streams hold until they transfer
  task automatic drive_inputs();
    if (!inst_valid || inst_fire) begin
      if ((inst_idx < n_prog) && (rand_bits(2) != 0)) begin
        inst_valid = 1'b1;
        inst       = prog[inst_idx];
      end else begin
        inst_valid = 1'b0;
      end
    end
    if (!mngr2proc_valid || mngr_fire) begin
      if ((mngr_idx < n_words) && (rand_bits(2) != 0)) begin
        mngr2proc_valid = 1'b1;
        mngr2proc_data  = m_words[mngr_idx];
      end else begin
        mngr2proc_valid = 1'b0;
      end
    end
    proc2mngr_ready = (rand_bits(3) > 2);
  endtask

  initial begin
    clk             = 1'b0;
    reset           = 1'b1;
    inst_valid      = 1'b0;
    proc2mngr_ready = 1'b0;
    lfsr            = 32'd96076;
    inst_idx        = 0;
    mngr_idx        = 0;
    model_mngr      = 0;
    out_count       = 0;
    check_count     = 0;
    err_count       = 0;
    inst_fire       = 1'b0;
    mngr_fire       = 1'b0;
    hold_pending    = 1'b0;
    hold_data       = '0;
    for (int r = 0; r < 8; r++) begin
      mregs[r] = '0;
    end
    build_program();
    // first instruction is a csrr mngr2proc parked on the bus without valid
    inst            = prog[0];
    // manager word offered early before any instruction
    mngr2proc_valid = 1'b1;
    mngr2proc_data  = m_words[0];

    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    // idle handshakes right after reset
    @(posedge clk);
    check_count += 2;
    if (proc2mngr_valid !== 1'b0) begin
      report_mismatch("reset_proc2mngr_valid", 32'd0, {31'b0, proc2mngr_valid});
    end
    if (mngr2proc_ready !== 1'b0) begin
      report_mismatch("reset_mngr2proc_ready", 32'd0, {31'b0, mngr2proc_ready});
    end
    #1;
    drive_inputs();

    cycles = 0;
    while (((inst_idx < n_prog) || (exp_q.size() != 0)) && (cycles < max_cycles)) begin
      @(posedge clk);
      observe_edge();
      #1;
      drive_inputs();
      cycles++;
    end

    if (cycles >= max_cycles) begin
      $display("timeout after %0d cycles with %0d of %0d instructions sent and %0d results due",
               cycles, inst_idx, n_prog, exp_q.size());
      err_count++;
    end
    // one manager word per csrr mngr2proc
    check_count++;
    if (mngr_idx != model_mngr) begin
      report_mismatch("mngr2proc_count", 32'(model_mngr), 32'(mngr_idx));
    end

    $display("checks %0d errors %0d instructions %0d proc2mngr %0d mngr2proc %0d cycles %0d",
             check_count, err_count, inst_idx, out_count, mngr_idx, cycles);
    if (err_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tiny_core.f
verilog/tiny_isa_pkg.sv
verilog/tiny_pipe_pkg.sv
verilog/tiny_regfile.sv
verilog/tiny_decode.sv
verilog/tiny_execute.sv
verilog/tiny_result.sv
verilog/tiny_core.sv
sim/tiny_core_tb.sv

// File: verilog/tiny_core.sv
// --------------------
// three-stage core d x w, all streams are valid/ready
// num_cores and core_id are read back through csrr
// --------------------
`default_nettype none

module tiny_core
  import tiny_pipe_pkg::*;
#(
  parameter int unsigned num_cores = 1,
  parameter int unsigned core_id   = 0
) (
  input  wire logic  clk,
  input  wire logic  reset,
  // instruction stream
  input  wire logic  inst_valid_i,
  input  wire word_t inst_i,
  output logic       inst_ready_o,
  // manager to core
  input  wire logic  mngr2proc_valid_i,
  input  wire word_t mngr2proc_data_i,
  output logic       mngr2proc_ready_o,
  // core to manager
  output logic       proc2mngr_valid_o,
  output word_t      proc2mngr_data_o,
  input  wire logic  proc2mngr_ready_i
);

  // --------------------
  // stage links
  // --------------------

  dx_t      dx;
  xw_t      xw;
  dest_t    x_dest;
  dest_t    w_dest;
  logic     advance;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    rdata1;
  word_t    rdata2;
  logic     rf_wen;
  reg_idx_t rf_waddr;
  word_t    rf_wdata;

  tiny_decode #(
    .num_cores (num_cores),
    .core_id   (core_id)
  ) u_decode (
    .inst_valid_i      (inst_valid_i),
    .inst_i            (inst_i),
    .inst_ready_o      (inst_ready_o),
    .mngr2proc_valid_i (mngr2proc_valid_i),
    .mngr2proc_data_i  (mngr2proc_data_i),
    .mngr2proc_ready_o (mngr2proc_ready_o),
    .rs1_o             (rs1),
    .rs2_o             (rs2),
    .rdata1_i          (rdata1),
    .rdata2_i          (rdata2),
    .x_dest_i          (x_dest),
    .w_dest_i          (w_dest),
    .advance_i         (advance),
    .dx_o              (dx)
  );

  tiny_execute u_execute (
    .clk       (clk),
    .reset     (reset),
    .dx_i      (dx),
    .advance_i (advance),
    .x_dest_o  (x_dest),
    .xw_o      (xw)
  );

  // w drives the advance enable seen by x and d
  tiny_result u_result (
    .clk               (clk),
    .reset             (reset),
    .xw_i              (xw),
    .proc2mngr_ready_i (proc2mngr_ready_i),
    .advance_o         (advance),
    .w_dest_o          (w_dest),
    .rf_wen_o          (rf_wen),
    .rf_waddr_o        (rf_waddr),
    .rf_wdata_o        (rf_wdata),
    .proc2mngr_valid_o (proc2mngr_valid_o),
    .proc2mngr_data_o  (proc2mngr_data_o)
  );

  tiny_regfile u_regfile (
    .clk      (clk),
    .rs1_i    (rs1),
    .rs2_i    (rs2),
    .wen_i    (rf_wen),
    .waddr_i  (rf_waddr),
    .wdata_i  (rf_wdata),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2)
  );

endmodule

`default_nettype wire

// File: verilog/tiny_decode.sv
// --------------------
// decodes the head of the instruction stream, no fetch register
// stalls on raw hazards against x and w, no bypassing
// --------------------
`default_nettype none

module tiny_decode
  import tiny_isa_pkg::*, tiny_pipe_pkg::*;
#(
  parameter int unsigned num_cores = 1,
  parameter int unsigned core_id   = 0
) (
  input  wire logic  inst_valid_i,
  input  wire word_t inst_i,
  output logic       inst_ready_o,
  input  wire logic  mngr2proc_valid_i,
  input  wire word_t mngr2proc_data_i,
  output logic       mngr2proc_ready_o,
  output reg_idx_t   rs1_o,
  output reg_idx_t   rs2_o,
  input  wire word_t rdata1_i,
  input  wire word_t rdata2_i,
  input  wire dest_t x_dest_i,
  input  wire dest_t w_dest_i,
  input  wire logic  advance_i,
  output dx_t        dx_o
);

  // operand b source
  typedef enum logic [2:0] {opb_rf, opb_imm_i, opb_imm_u, opb_mngr, opb_csr} opb_sel_e;

  // true when a source register waits on a pending write
  function automatic logic raw_hit(reg_idx_t rs, logic used, dest_t d);
    return used && (rs != '0) && d.valid && d.rf_wen && (rs == d.rd);
  endfunction

  // alu op from funct3, alt picks sub or sra
  function automatic alu_op_e alu_of(logic [funct3_w-1:0] f3, logic alt);
    case (f3)
      f3_add_sub: return alt ? alu_sub : alu_add;
      f3_sll:     return alu_sll;
      f3_slt:     return alu_slt;
      f3_sltu:    return alu_sltu;
      f3_xor:     return alu_xor;
      f3_srl_sra: return alt ? alu_sra : alu_srl;
      f3_or:      return alu_or;
      default:    return alu_and;
    endcase
  endfunction

  // --------------------
  // field extraction
  // --------------------

  logic [opcode_w-1:0] opcode;
  logic [funct3_w-1:0] funct3;
  logic [funct7_w-1:0] funct7;
  logic [csr_w-1:0]    csr;
  reg_idx_t            rd;

  assign opcode = inst_i[6:0];
  assign rd     = inst_i[11:7];
  assign funct3 = inst_i[14:12];
  assign rs1_o  = inst_i[19:15];
  assign rs2_o  = inst_i[24:20];
  assign funct7 = inst_i[31:25];
  assign csr    = inst_i[31:20];

  // --------------------
  // control table
  // --------------------

  alu_op_e  alu_op;
  opb_sel_e opb_sel;
  logic     rs1_use;
  logic     rs2_use;
  logic     rf_wen;
  logic     to_mngr;
  logic     mngr_rd;

  always_comb begin
    // unknown encodings fall through as harmless no-ops
    alu_op  = alu_add;
    opb_sel = opb_rf;
    rs1_use = 1'b0;
    rs2_use = 1'b0;
    rf_wen  = 1'b0;
    to_mngr = 1'b0;
    mngr_rd = 1'b0;
    case (opcode)
      opcode_op: begin
        // only sub and sra take the alt funct7
        if ((funct7 == funct7_base) ||
            ((funct7 == funct7_alt) && ((funct3 == f3_add_sub) || (funct3 == f3_srl_sra)))) begin
          alu_op  = alu_of(funct3, funct7 == funct7_alt);
          rs1_use = 1'b1;
          rs2_use = 1'b1;
          rf_wen  = 1'b1;
        end
      end
      opcode_op_imm: begin
        if (((funct3 != f3_sll) && (funct3 != f3_srl_sra)) || (funct7 == funct7_base) ||
            ((funct3 == f3_srl_sra) && (funct7 == funct7_alt))) begin
          alu_op  = alu_of(funct3, (funct3 == f3_srl_sra) && (funct7 == funct7_alt));
          opb_sel = opb_imm_i;
          rs1_use = 1'b1;
          rf_wen  = 1'b1;
        end
      end
      opcode_lui: begin
        alu_op  = alu_pass_b;
        opb_sel = opb_imm_u;
        rf_wen  = 1'b1;
      end
      opcode_system: begin
        // csrr
        if ((funct3 == f3_csrrs) && (rs1_o == '0)) begin
          alu_op = alu_pass_b;
          if (csr == csr_mngr2proc) begin
            opb_sel = opb_mngr;
            mngr_rd = 1'b1;
            rf_wen  = 1'b1;
          end else if ((csr == csr_numcores) || (csr == csr_coreid)) begin
            opb_sel = opb_csr;
            rf_wen  = 1'b1;
          end
        end
        // csrw, value rides on op_a
        if ((funct3 == f3_csrrw) && (rd == '0) && (csr == csr_proc2mngr)) begin
          rs1_use = 1'b1;
          to_mngr = 1'b1;
        end
      end
      default: ;
    endcase
  end

  // --------------------
  // stalls and handoff
  // --------------------

  logic hazard;
  logic mngr_stall;
  logic fire;

  assign hazard = raw_hit(rs1_o, rs1_use, x_dest_i) || raw_hit(rs1_o, rs1_use, w_dest_i) ||
                  raw_hit(rs2_o, rs2_use, x_dest_i) || raw_hit(rs2_o, rs2_use, w_dest_i);
  assign mngr_stall = mngr_rd && !mngr2proc_valid_i;

  // fire only when x can take the instruction
  assign fire              = inst_valid_i && !hazard && !mngr_stall && advance_i;
  assign inst_ready_o      = fire;
  assign mngr2proc_ready_o = fire && mngr_rd;

  always_comb begin
    dx_o.valid   = fire;
    dx_o.alu_op  = alu_op;
    dx_o.op_a    = rdata1_i;
    dx_o.rd      = rd;
    dx_o.rf_wen  = rf_wen;
    dx_o.to_mngr = to_mngr;
    case (opb_sel)
      opb_imm_i: dx_o.op_b = {{(xlen-12){inst_i[31]}}, inst_i[31:20]};
      opb_imm_u: dx_o.op_b = {inst_i[31:12], 12'b0};
      opb_mngr:  dx_o.op_b = mngr2proc_data_i;
      opb_csr:   dx_o.op_b = (csr == csr_numcores) ? word_t'(num_cores) : word_t'(core_id);
      default:   dx_o.op_b = rdata2_i;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/tiny_execute.sv
// --------------------
// x stage register and alu, single cycle
// holds while w is stalled
// --------------------
`default_nettype none

module tiny_execute
  import tiny_isa_pkg::*, tiny_pipe_pkg::*;
(
  input  wire logic clk,
  input  wire logic reset,
  input  wire dx_t  dx_i,
  input  wire logic advance_i,
  output dest_t     x_dest_o,
  output xw_t       xw_o
);

  dx_t x_reg;

  // --------------------
  // pipeline register
  // --------------------

  // only valid is cleared, payload is don't-care while invalid
  always_ff @(posedge clk) begin
    if (reset) begin
      x_reg.valid <= 1'b0;
    end else if (advance_i) begin
      x_reg <= dx_i;
    end
  end

  // --------------------
  // alu
  // --------------------

  logic [4:0] shamt;
  word_t      alu_out;

  assign shamt = x_reg.op_b[4:0];

  always_comb begin
    case (x_reg.alu_op)
      alu_add:    alu_out = x_reg.op_a + x_reg.op_b;
      alu_sub:    alu_out = x_reg.op_a - x_reg.op_b;
      alu_and:    alu_out = x_reg.op_a & x_reg.op_b;
      alu_or:     alu_out = x_reg.op_a | x_reg.op_b;
      alu_xor:    alu_out = x_reg.op_a ^ x_reg.op_b;
      // compares give 0 or 1
      alu_slt:    alu_out = word_t'($signed(x_reg.op_a) < $signed(x_reg.op_b));
      alu_sltu:   alu_out = word_t'(x_reg.op_a < x_reg.op_b);
      alu_sll:    alu_out = x_reg.op_a << shamt;
      alu_srl:    alu_out = x_reg.op_a >> shamt;
      alu_sra:    alu_out = word_t'($signed(x_reg.op_a) >>> shamt);
      alu_pass_b: alu_out = x_reg.op_b;
      default:    alu_out = '0;
    endcase
  end

  // --------------------
  // outputs
  // --------------------

  // pending write for the hazard check in d
  assign x_dest_o.valid  = x_reg.valid;
  assign x_dest_o.rd     = x_reg.rd;
  assign x_dest_o.rf_wen = x_reg.rf_wen;

  // csrw sends rs1 straight through
  assign xw_o.valid   = x_reg.valid;
  assign xw_o.result  = x_reg.to_mngr ? x_reg.op_a : alu_out;
  assign xw_o.rd      = x_reg.rd;
  assign xw_o.rf_wen  = x_reg.rf_wen;
  assign xw_o.to_mngr = x_reg.to_mngr;

endmodule

`default_nettype wire

// File: verilog/tiny_isa_pkg.sv
// --------------------
// rv32i subset encodings only; csr numbers follow the tinyrv convention
// csrr is csrrs with rs1 = x0, csrw is csrrw with rd = x0
// --------------------
`default_nettype none

package tiny_isa_pkg;

  // --------------------
  // widths
  // --------------------

  localparam int unsigned xlen      = 32;
  localparam int unsigned reg_idx_w = 5;
  localparam int unsigned opcode_w  = 7;
  localparam int unsigned funct3_w  = 3;
  localparam int unsigned funct7_w  = 7;
  localparam int unsigned csr_w     = 12;

  // --------------------
  // major opcodes
  // --------------------

  localparam logic [opcode_w-1:0] opcode_op     = 7'h33;
  localparam logic [opcode_w-1:0] opcode_op_imm = 7'h13;
  localparam logic [opcode_w-1:0] opcode_lui    = 7'h37;
  localparam logic [opcode_w-1:0] opcode_system = 7'h73;

  // funct3 for op and op-imm
  localparam logic [funct3_w-1:0] f3_add_sub = 3'd0;
  localparam logic [funct3_w-1:0] f3_sll     = 3'd1;
  localparam logic [funct3_w-1:0] f3_slt     = 3'd2;
  localparam logic [funct3_w-1:0] f3_sltu    = 3'd3;
  localparam logic [funct3_w-1:0] f3_xor     = 3'd4;
  localparam logic [funct3_w-1:0] f3_srl_sra = 3'd5;
  localparam logic [funct3_w-1:0] f3_or      = 3'd6;
  localparam logic [funct3_w-1:0] f3_and     = 3'd7;

  // funct3 for system
  localparam logic [funct3_w-1:0] f3_csrrw = 3'd1;
  localparam logic [funct3_w-1:0] f3_csrrs = 3'd2;

  // funct7 values, alt selects sub and sra
  localparam logic [funct7_w-1:0] funct7_base = 7'h00;
  localparam logic [funct7_w-1:0] funct7_alt  = 7'h20;

  // --------------------
  // csr numbers
  // --------------------

  localparam logic [csr_w-1:0] csr_proc2mngr = 12'h7C0;
  localparam logic [csr_w-1:0] csr_mngr2proc = 12'hFC0;
  localparam logic [csr_w-1:0] csr_numcores  = 12'hFC1;
  localparam logic [csr_w-1:0] csr_coreid    = 12'hF14;

  // alu functions, pass_b forwards operand b untouched
  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra, alu_pass_b
  } alu_op_e;

endpackage

`default_nettype wire

// File: verilog/tiny_pipe_pkg.sv
// --------------------
// stage-to-stage records, valid bit first in each
// --------------------
`default_nettype none

package tiny_pipe_pkg;
  import tiny_isa_pkg::*;

  typedef logic [xlen-1:0]      word_t;
  typedef logic [reg_idx_w-1:0] reg_idx_t;

  // --------------------
  // decode to execute
  // --------------------

  typedef struct packed {
    logic     valid;
    alu_op_e  alu_op;
    word_t    op_a;
    word_t    op_b;
    reg_idx_t rd;
    logic     rf_wen;
    // csrw, result goes to the manager
    logic     to_mngr;
  } dx_t;

  // --------------------
  // execute to result
  // --------------------

  typedef struct packed {
    logic     valid;
    word_t    result;
    reg_idx_t rd;
    logic     rf_wen;
    logic     to_mngr;
  } xw_t;

  // pending write of a later stage, looked at by the hazard check
  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    logic     rf_wen;
  } dest_t;

endpackage

`default_nettype wire

// File: verilog/tiny_regfile.sv
// --------------------
// no reset, contents undefined until written
// x0 reads zero and drops writes
// --------------------
`default_nettype none

module tiny_regfile
  import tiny_pipe_pkg::*;
(
  input  wire logic     clk,
  input  wire reg_idx_t rs1_i,
  input  wire reg_idx_t rs2_i,
  input  wire logic     wen_i,
  input  wire reg_idx_t waddr_i,
  input  wire word_t    wdata_i,
  output word_t         rdata1_o,
  output word_t         rdata2_o
);

  word_t regs [32];

  // write port, x0 is never stored
  always_ff @(posedge clk) begin
    if (wen_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // combinational reads
  // a write in this cycle is seen only after the edge
  always_comb begin
    rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];
  end

endmodule

`default_nettype wire

// File: verilog/tiny_result.sv
// --------------------
// w stage, only stall source is proc2mngr back-pressure
// --------------------
`default_nettype none

module tiny_result
  import tiny_pipe_pkg::*;
(
  input  wire logic clk,
  input  wire logic reset,
  input  wire xw_t  xw_i,
  input  wire logic proc2mngr_ready_i,
  output logic      advance_o,
  output dest_t     w_dest_o,
  output logic      rf_wen_o,
  output reg_idx_t  rf_waddr_o,
  output word_t     rf_wdata_o,
  output logic      proc2mngr_valid_o,
  output word_t     proc2mngr_data_o
);

  xw_t  w_reg;
  logic w_stall;

  // manager not ready for a pending csrw
  assign w_stall   = w_reg.valid && w_reg.to_mngr && !proc2mngr_ready_i;
  assign advance_o = !w_stall;

  // register holds under stall so valid and data stay put
  always_ff @(posedge clk) begin
    if (reset) begin
      w_reg.valid <= 1'b0;
    end else if (!w_stall) begin
      w_reg <= xw_i;
    end
  end

  // --------------------
  // register file write
  // --------------------

  // one write, on the edge that retires the instruction
  assign rf_wen_o   = w_reg.valid && w_reg.rf_wen && !w_stall;
  assign rf_waddr_o = w_reg.rd;
  assign rf_wdata_o = w_reg.result;

  assign w_dest_o.valid  = w_reg.valid;
  assign w_dest_o.rd     = w_reg.rd;
  assign w_dest_o.rf_wen = w_reg.rf_wen;

  // manager port, valid does not look at ready
  assign proc2mngr_valid_o = w_reg.valid && w_reg.to_mngr;
  assign proc2mngr_data_o  = w_reg.result;

endmodule

`default_nettype wire
